/* list.f */
+incdir+verilog
verilog/npu_pkg.sv
verilog/ucode_fetch.sv
verilog/ucode_dispatch.sv
verilog/exec_engine.sv
verilog/engine_scoreboard.sv
verilog/npu_core.sv
tb/tb_npu.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_npu -f list.f -o tb_npu_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_npu_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* tb/tb_npu.sv */
/*
 * Testbench for the NPU sequencing core. Builds random microcode programs
 * from a fixed seed, loads and runs them back to back, and checks the issue
 * trace, engine occupancy, barriers and end of run against a list model.
 */

`default_nettype none
`include "npu_cfg.svh"

module tb_npu
    import npu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst_int_n;
    logic        start_i;
    logic        ucode_we_i;
    pc_t         ucode_waddr_i;
    instr_t      ucode_wdata_i;
    pc_t         ucode_len_i;
    logic        busy_o;
    logic        done_o;
    logic        issue_valid_o;
    npu_opcode_e issue_op_o;
    len_t        issue_len_o;
    eng_vec_t    eng_busy_o;

    // Program image and expected issue list
    instr_t      prog [`NPU_UCODE_DEPTH];
    npu_opcode_e exp_op_q [$];
    len_t        exp_len_q [$];
    bit          exp_bar_q [$];
    int          rem [`NPU_NUM_ENGINES];

    int   seed = 4;
    int   errors = 0;
    int   checks = 0;
    int   issues = 0;
    int   tests = 0;
    logic done_prev = 1'b0;
    bit   run_on = 1'b0;

    npu_core dut0 (
        .clk           (clk),
        .rst_int_n     (rst_int_n),
        .start_i       (start_i),
        .ucode_we_i    (ucode_we_i),
        .ucode_waddr_i (ucode_waddr_i),
        .ucode_wdata_i (ucode_wdata_i),
        .ucode_len_i   (ucode_len_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .issue_valid_o (issue_valid_o),
        .issue_op_o    (issue_op_o),
        .issue_len_o   (issue_len_o),
        .eng_busy_o    (eng_busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_op(input npu_opcode_e got, input npu_opcode_e expected,
                            input string what);
        checks++;
        if (got !== expected) begin
            $display("ERR %0t: %s got %s expected %s", $time, what, got.name(), expected.name());
            errors++;
        end
    endtask

    task automatic check_len(input len_t got, input len_t expected, input string what);
        checks++;
        if (got !== expected) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        checks++;
        if (got !== expected) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, expected);
            errors++;
        end
    endtask

    // ========================================
    // Program generation and model
    // ========================================
    task automatic build_program(output int n, output bit has_end);
        int         i;
        int         r;
        int         end_pos;
        logic [3:0] op;
        bit         bar;
        n = 4 + int'($unsigned($random(seed)) % 37);
        for (i = 0; i < n; i++) begin
            r = int'($unsigned($random(seed)) % 16);
            if (r < 10) begin
                op = 4'(1 + r % 5);
            end else if (r < 12) begin
                op = OP_NOP;
            end else if (r < 14) begin
                op = OP_BARRIER;
            end else begin
                // Undefined codes, decoded as NOP
                op = 4'(8 + $unsigned($random(seed)) % 8);
            end
            prog[i] = {op, 20'($random(seed)), 4'd0, 4'($random(seed))};
        end
        has_end = 1'($random(seed));
        if (has_end) begin
            end_pos = int'($unsigned($random(seed)) % n);
            prog[end_pos][31:28] = OP_END;
        end
        // Engine instructions up to the first END, flagged after a barrier
        bar = 1'b0;
        for (i = 0; i < n; i++) begin
            op = prog[i][31:28];
            if (op == OP_END) break;
            if (op == OP_BARRIER) begin
                bar = 1'b1;
            end else if (op >= 4'd1 && op <= 4'd5) begin
                exp_op_q.push_back(npu_opcode_e'(op));
                exp_len_q.push_back(prog[i][`NPU_LEN_W-1:0]);
                exp_bar_q.push_back(bar);
                bar = 1'b0;
            end
        end
    endtask

    task automatic load_program(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            ucode_we_i    <= 1'b1;
            ucode_waddr_i <= pc_t'(i);
            ucode_wdata_i <= prog[i];
        end
        @(posedge clk);
        ucode_we_i  <= 1'b0;
        ucode_len_i <= pc_t'(n);
    endtask

    task automatic wait_done(input int limit, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b1;
        while (!done_o && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_o) begin
            $display("Timeout: done_o did not rise within %0d cycles", limit);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic run_test(input int t, output bit ok);
        int n;
        bit has_end;
        int err0;
        int iss0;
        err0 = errors;
        iss0 = issues;
        build_program(n, has_end);
        load_program(n);
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        run_on = 1'b1;
        @(negedge clk);
        check_flag(done_o, 1'b0, "done_o after start");
        check_flag(busy_o, 1'b1, "busy_o after start");
        wait_done(4000, ok);
        // A few idle cycles so stray issues show up
        repeat (4) @(negedge clk);
        check_flag(logic'(exp_op_q.size() == 0), 1'b1, "all engine instructions issued");
        tests++;
        $display("test %0d: %0d words, end %0d, %0d issues, %0d errors",
                 t, n, has_end, issues - iss0, errors - err0);
    endtask

    // ========================================
    // Output monitor, sampled mid-cycle
    // ========================================
    always @(negedge clk) begin : monitor
        int          e;
        bit          bar;
        npu_opcode_e exp_op;
        len_t        exp_len;
        if (rst_int_n) begin
            for (e = 0; e < `NPU_NUM_ENGINES; e++) begin
                check_flag(eng_busy_o[e], logic'(rem[e] != 0), $sformatf("eng_busy_o[%0d]", e));
                if (rem[e] != 0) rem[e]--;
            end
            if (issue_valid_o) begin
                issues++;
                if (exp_op_q.size() == 0) begin
                    $display("Unexpected issue of %s at %0t with no instruction left",
                             issue_op_o.name(), $time);
                    errors++;
                end else begin
                    exp_op  = exp_op_q.pop_front();
                    exp_len = exp_len_q.pop_front();
                    bar     = exp_bar_q.pop_front();
                    check_op(issue_op_o, exp_op, "issue_op_o");
                    check_len(issue_len_o, exp_len, "issue_len_o");
                    e = int'(exp_op) - 1;
                    if (e >= 0 && e < `NPU_NUM_ENGINES) begin
                        check_flag(eng_busy_o[e], 1'b0, "target engine free at issue");
                        // Busy from the next cycle for len+2 cycles
                        rem[e] = int'(exp_len) + 2;
                    end
                    if (bar) check_flag(logic'(|eng_busy_o), 1'b0, "engines idle after barrier");
                end
            end
            if (done_o && !done_prev) begin
                check_flag(logic'(|eng_busy_o), 1'b0, "engines idle at done");
                check_flag(logic'(exp_op_q.size() == 0), 1'b1, "issues complete at done");
            end
            if (done_o) begin
                check_flag(busy_o, 1'b0, "busy_o low while done");
            end else if (run_on) begin
                check_flag(busy_o, 1'b1, "busy_o high while running");
            end
            done_prev = done_o;
        end
    end

    initial begin
        int t;
        bit ok;
        rst_int_n     = 1'b0;
        start_i       = 1'b0;
        ucode_we_i    = 1'b0;
        ucode_waddr_i = '0;
        ucode_wdata_i = '0;
        ucode_len_i   = '0;
        repeat (8) @(posedge clk);
        rst_int_n <= 1'b1;
        @(negedge clk);
        check_flag(done_o, 1'b0, "done_o after reset");
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(issue_valid_o, 1'b0, "issue_valid_o after reset");
        check_flag(logic'(|eng_busy_o), 1'b0, "eng_busy_o after reset");
        ok = 1'b1;
        for (t = 0; t < 8 && ok; t++) begin
            run_test(t, ok);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/engine_scoreboard.sv */
/*
 * In-flight tracking per engine. A bit is set by its issue strobe and
 * cleared by the engine's done pulse; all_idle reports that every bit
 * is clear.
 */

`default_nettype none

module engine_scoreboard
    import npu_pkg::*;
(
    input  wire           clk,
    input  wire           rst_int_n,
    input  wire eng_vec_t issue_vec_i,
    input  wire eng_vec_t done_vec_i,
    output eng_vec_t      eng_busy_o,
    output logic          all_idle_o
);

    eng_vec_t busy_q;
    eng_vec_t busy_next;
    logic     all_idle_q;

    // ========================================
    // In-flight bits
    // ========================================

    // Issue and done never hit the same engine in one cycle
    assign busy_next = (busy_q & ~done_vec_i) | issue_vec_i;

    always_ff @(posedge clk or negedge rst_int_n) begin
        if (!rst_int_n) begin
            busy_q     <= '0;
            all_idle_q <= 1'b1;
        end else begin
            busy_q     <= busy_next;
            // Registered alongside the bits so both agree every cycle
            all_idle_q <= ~|busy_next;
        end
    end

    assign eng_busy_o = busy_q;
    assign all_idle_o = all_idle_q;

endmodule

`default_nettype wire

/* verilog/exec_engine.sv */
/*
 * Occupancy model of one compute engine. A command loads the work
 * length; the engine stays busy for len+1 cycles, then pulses done.
 */

`default_nettype none

module exec_engine
    import npu_pkg::*;
(
    input  wire       clk,
    input  wire       rst_int_n,
    input  wire       cmd_valid_i,
    input  wire len_t cmd_len_i,
    output logic      done_o
);

    logic busy_q;
    len_t count_q;
    logic done_q;

    always_ff @(posedge clk or negedge rst_int_n) begin
        if (!rst_int_n) begin
            busy_q  <= 1'b0;
            count_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (cmd_valid_i && !busy_q) begin
                busy_q  <= 1'b1;
                count_q <= cmd_len_i;
            end else if (busy_q) begin
                // Count reaches zero on the last busy cycle
                if (count_q == '0) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    count_q <= count_q - len_t'(1);
                end
            end
        end
    end

    assign done_o = done_q;

endmodule

`default_nettype wire

/* verilog/npu_cfg.svh */
/*
 * Build-time sizes of the NPU sequencing core.
 * Included by the package, the RTL and the testbench.
 */

`ifndef NPU_CFG_SVH
`define NPU_CFG_SVH

// Compute engines: GEMM, softmax, layernorm, GELU, vector
`define NPU_NUM_ENGINES 5

// Microcode store
`define NPU_UCODE_DEPTH 64
`define NPU_PC_W        6

// Instruction word and its work-length field
`define NPU_INSTR_W     32
`define NPU_LEN_W       8

`endif

/* verilog/npu_core.sv */
/*
 * Top level of the NPU sequencing core. Connects microcode fetch,
 * dispatch, the engine scoreboard and the array of engine models.
 */

`default_nettype none
`include "npu_cfg.svh"

module npu_core
    import npu_pkg::*;
(
    input  wire              clk,
    input  wire              rst_int_n,
    input  wire              start_i,

    // Program load
    input  wire              ucode_we_i,
    input  wire pc_t         ucode_waddr_i,
    input  wire instr_t      ucode_wdata_i,
    input  wire pc_t         ucode_len_i,

    // Status and issue trace
    output wire              busy_o,
    output wire              done_o,
    output wire              issue_valid_o,
    output wire npu_opcode_e issue_op_o,
    output wire len_t        issue_len_o,
    output wire eng_vec_t    eng_busy_o
);

    logic     instr_valid;
    logic     instr_ready;
    instr_t   instr;
    logic     prog_end;
    eng_vec_t issue_vec;
    eng_vec_t done_vec;
    logic     all_idle;

    // ========================================
    // Fetch and dispatch
    // ========================================
    ucode_fetch u_fetch (
        .clk           (clk),
        .rst_int_n     (rst_int_n),
        .start_i       (start_i),
        .ucode_we_i    (ucode_we_i),
        .ucode_waddr_i (ucode_waddr_i),
        .ucode_wdata_i (ucode_wdata_i),
        .ucode_len_i   (ucode_len_i),
        .instr_ready_i (instr_ready),
        .instr_valid_o (instr_valid),
        .instr_o       (instr),
        .prog_end_o    (prog_end)
    );

    ucode_dispatch u_dispatch (
        .clk           (clk),
        .rst_int_n     (rst_int_n),
        .start_i       (start_i),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .prog_end_i    (prog_end),
        .instr_ready_o (instr_ready),
        .eng_busy_i    (eng_busy_o),
        .all_idle_i    (all_idle),
        .issue_vec_o   (issue_vec),
        .issue_len_o   (issue_len_o),
        .issue_op_o    (issue_op_o),
        .issue_valid_o (issue_valid_o),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    // ========================================
    // Engines and scoreboard
    // ========================================
    for (genvar g = 0; g < `NPU_NUM_ENGINES; g++) begin : g_engine
        // Shared length bus, each engine loads on its own issue bit
        exec_engine u_engine (
            .clk         (clk),
            .rst_int_n   (rst_int_n),
            .cmd_valid_i (issue_vec[g]),
            .cmd_len_i   (issue_len_o),
            .done_o      (done_vec[g])
        );
    end

    engine_scoreboard u_scoreboard (
        .clk         (clk),
        .rst_int_n   (rst_int_n),
        .issue_vec_i (issue_vec),
        .done_vec_i  (done_vec),
        .eng_busy_o  (eng_busy_o),
        .all_idle_o  (all_idle)
    );

endmodule

`default_nettype wire

/* verilog/npu_pkg.sv */
/*
 * Shared types of the NPU sequencing core: opcodes, fetch states and
 * the vector types used between fetch, dispatch, engines and scoreboard.
 * Modules pull these in with a wildcard import.
 */

`default_nettype none
`include "npu_cfg.svh"

package npu_pkg;

    // ========================================
    // Instruction set
    // ========================================

    // Opcode lives in the top 4 bits of the word
    typedef enum logic [3:0] {
        OP_NOP       = 4'd0,
        OP_GEMM      = 4'd1,
        OP_SOFTMAX   = 4'd2,
        OP_LAYERNORM = 4'd3,
        OP_GELU      = 4'd4,
        OP_VEC       = 4'd5,
        OP_BARRIER   = 4'd6,
        OP_END       = 4'd7
    } npu_opcode_e;

    // Work length in bits 7:0, rest ignored
    typedef logic [`NPU_INSTR_W-1:0]     instr_t;
    typedef logic [`NPU_LEN_W-1:0]       len_t;
    typedef logic [`NPU_PC_W-1:0]        pc_t;

    // One bit per engine, index = opcode - 1
    typedef logic [`NPU_NUM_ENGINES-1:0] eng_vec_t;

    // ========================================
    // Fetch sequencer
    // ========================================
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        READ = 2'd1,
        HOLD = 2'd2,
        END  = 2'd3
    } fetch_state_e;

endpackage

`default_nettype wire

/* verilog/ucode_dispatch.sv */
/*
 * Decode and dispatch. Takes words from fetch, issues engine opcodes
 * to free engines, holds BARRIER and END until every engine is idle,
 * and owns the running and done flags of a program run.
 */

`default_nettype none
`include "npu_cfg.svh"

module ucode_dispatch
    import npu_pkg::*;
(
    input  wire           clk,
    input  wire           rst_int_n,
    input  wire           start_i,

    // From fetch
    input  wire           instr_valid_i,
    input  wire instr_t   instr_i,
    input  wire           prog_end_i,
    output logic          instr_ready_o,

    // From scoreboard
    input  wire eng_vec_t eng_busy_i,
    input  wire           all_idle_i,

    // Issue toward engines
    output eng_vec_t      issue_vec_o,
    output len_t          issue_len_o,
    output npu_opcode_e   issue_op_o,
    output logic          issue_valid_o,

    // Run status
    output logic          busy_o,
    output logic          done_o
);

    logic [3:0]  op_code;
    npu_opcode_e op;
    logic        is_eng;
    eng_vec_t    target;
    logic        can_take;
    logic        accept;
    logic        finish;
    logic        running_q;
    logic        done_q;

    // ========================================
    // Decode
    // ========================================
    assign op_code = instr_i[`NPU_INSTR_W-1 -: 4];

    // Unknown codes fall back to NOP
    always_comb begin
        case (op_code)
            OP_GEMM, OP_SOFTMAX, OP_LAYERNORM, OP_GELU, OP_VEC,
            OP_BARRIER, OP_END: op = npu_opcode_e'(op_code);
            default:            op = OP_NOP;
        endcase
    end

    // One-hot engine select, engine index is opcode - 1
    assign is_eng = (op >= OP_GEMM) && (op <= OP_VEC);
    assign target = is_eng ? (eng_vec_t'(1) << (op_code - 4'd1)) : '0;

    // ========================================
    // Issue gating
    // ========================================
    always_comb begin
        case (op)
            OP_NOP:             can_take = 1'b1;
            OP_BARRIER, OP_END: can_take = all_idle_i;
            default:            can_take = ~|(eng_busy_i & target);
        endcase
    end

    assign instr_ready_o = running_q & can_take;
    assign accept        = instr_ready_o & instr_valid_i;

    assign issue_vec_o   = accept ? target : '0;
    assign issue_valid_o = accept & is_eng;
    assign issue_op_o    = op;
    assign issue_len_o   = instr_i[`NPU_LEN_W-1:0];

    // Run ends on END or when the program drains without one
    assign finish = running_q & ((accept & (op == OP_END)) | (prog_end_i & all_idle_i));

    // ========================================
    // Run flags
    // ========================================
    always_ff @(posedge clk or negedge rst_int_n) begin
        if (!rst_int_n) begin
            running_q <= 1'b0;
            done_q    <= 1'b0;
        end else if (start_i) begin
            running_q <= 1'b1;
            done_q    <= 1'b0;
        end else if (finish) begin
            running_q <= 1'b0;
            done_q    <= 1'b1;
        end
    end

    assign busy_o = running_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

/* verilog/ucode_fetch.sv */
/*
 * Microcode store and fetch sequencer. The program is written through a
 * plain write strobe; start_i rewinds the pc and words are read one per
 * two cycles into a holding register until dispatch takes them.
 */

`default_nettype none
`include "npu_cfg.svh"

module ucode_fetch
    import npu_pkg::*;
(
    input  wire         clk,
    input  wire         rst_int_n,
    input  wire         start_i,

    // Program load port
    input  wire         ucode_we_i,
    input  wire pc_t    ucode_waddr_i,
    input  wire instr_t ucode_wdata_i,
    input  wire pc_t    ucode_len_i,

    // Toward dispatch
    input  wire         instr_ready_i,
    output logic        instr_valid_o,
    output instr_t      instr_o,
    output logic        prog_end_o
);

    instr_t       ucode_mem [`NPU_UCODE_DEPTH];
    instr_t       instr_q;
    fetch_state_e state_q;
    pc_t          pc_q;

    // ========================================
    // Microcode memory
    // ========================================

    // Write port and one-cycle synchronous read
    always_ff @(posedge clk) begin
        if (ucode_we_i) begin
            ucode_mem[ucode_waddr_i] <= ucode_wdata_i;
        end
        if (state_q == READ) begin
            instr_q <= ucode_mem[pc_q];
        end
    end

    // ========================================
    // Fetch sequencer
    // ========================================
    always_ff @(posedge clk or negedge rst_int_n) begin
        if (!rst_int_n) begin
            state_q <= IDLE;
            pc_q    <= '0;
        end else if (start_i) begin
            // Restart from word 0, empty program ends at once
            pc_q <= '0;
            if (ucode_len_i == '0) begin
                state_q <= END;
            end else begin
                state_q <= READ;
            end
        end else begin
            case (state_q)
                READ: begin
                    pc_q    <= pc_q + pc_t'(1);
                    state_q <= HOLD;
                end
                HOLD: begin
                    // Word stays put until dispatch takes it
                    if (instr_ready_i) begin
                        if (pc_q == ucode_len_i) begin
                            state_q <= END;
                        end else begin
                            state_q <= READ;
                        end
                    end
                end
                default: begin
                    // IDLE and END wait for the next start
                    state_q <= state_q;
                end
            endcase
        end
    end

    assign instr_valid_o = (state_q == HOLD);
    assign instr_o       = instr_q;

    // Whole program handed over, nothing pending
    assign prog_end_o    = (state_q == END);

endmodule

`default_nettype wire
